//--- hdl/tx_cfg_pkg.sv
// descriptor layout assumes a 64-bit {cts_config, desc_word} entry; payload length is 13 bits
`default_nettype none

package tx_cfg_pkg;

    // priority queues, 0 is served first
    localparam int NUM_QUEUES = 4;

    // descriptor as stored in a queue
    localparam int DESC_W = 64;
    // payload word count in the low bits
    localparam int LEN_W = 13;

    // upper half comes from cts_config
    localparam int CTS_EN_BIT   = 63;
    localparam int RATE_SEL_BIT = 62;
    localparam int RATE_W       = 4;
    localparam int PKT_RATE_LSB = 32;
    localparam int CTS_RATE_LSB = 36;
    localparam int DUR_W        = 16;
    localparam int DUR_LSB      = 40;

    // phy start strobe length in clocks
    localparam int START_PULSE_CYCLES = 6;

    typedef enum logic [1:0] {
        ARB_IDLE, ARB_FETCH, ARB_HANDOFF, ARB_WAIT_DONE
    } arb_state_t;

    typedef enum logic [2:0] {
        WR_IDLE, WR_JUDGE, WR_CTS, WR_SIFS, WR_PAYLOAD
    } wr_state_t;

endpackage

`default_nettype wire

//--- hdl/wifi_frame_pkg.sv
// cts-to-self constants only; the signal length is fixed at 14 bytes and the parity relies on it
`default_nettype none

package wifi_frame_pkg;

    // header words ahead of the payload in the buffer
    localparam int CTS_WORDS = 4;

    // signal field length for a cts frame
    localparam logic [11:0] SIGNAL_LEN = 12'd14;

    // frame control of a cts
    localparam logic [1:0] FC_TYPE_CTRL   = 2'b01;
    localparam logic [3:0] FC_SUBTYPE_CTS = 4'b1100;

    // even parity over rate and length
    // 14 has three ones, so only the rate bits matter
    function automatic logic signal_parity(input logic [3:0] rate);
        return ~(^rate);
    endfunction

endpackage

`default_nettype wire

//--- hdl/desc_queues.sv
// QUEUE_DEPTH must be a power of two; a commit into a full queue is silently dropped
`default_nettype none

module desc_queues #(
    parameter int QUEUE_DEPTH = 64,
    localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1
) (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire                               commit,
    input  wire [1:0]                         commit_queue,
    input  wire [tx_cfg_pkg::DESC_W-1:0]      desc_in,
    input  wire                               pop,
    input  wire [1:0]                         pop_idx,
    output logic [tx_cfg_pkg::NUM_QUEUES-1:0] queue_empty,
    output logic [tx_cfg_pkg::DESC_W-1:0]     head_desc,
    output logic [CNT_W-1:0]                  queue_count0,
    output logic [CNT_W-1:0]                  queue_count1,
    output logic [CNT_W-1:0]                  queue_count2,
    output logic [CNT_W-1:0]                  queue_count3
);

    localparam int NQ    = tx_cfg_pkg::NUM_QUEUES;
    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    logic [tx_cfg_pkg::DESC_W-1:0] mem [NQ][QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr [NQ];
    logic [PTR_W-1:0] rd_ptr [NQ];
    logic [CNT_W-1:0] count [NQ];
    logic             commit_d;
    logic             commit_fall;
    logic [NQ-1:0]    push_sel;
    logic [NQ-1:0]    push_ok;
    logic [NQ-1:0]    pop_hit;
    logic [tx_cfg_pkg::DESC_W-1:0] push_desc;

    // host lowers commit once the dma is done
    assign commit_fall = commit_d && !commit;

    always_comb begin
        for (int q = 0; q < NQ; q++) begin
            queue_empty[q] = (count[q] == '0);
            // full queue drops the entry
            push_ok[q] = push_sel[q] && (count[q] != CNT_W'(QUEUE_DEPTH));
            pop_hit[q] = pop && (pop_idx == 2'(q)) && !queue_empty[q];
        end
    end

    // edge detect and one-hot write strobe, one cycle behind the fall
    always_ff @(posedge clk) begin
        if (!rstn) begin
            commit_d <= 1'b0;
            push_sel <= '0;
        end else begin
            commit_d <= commit;
            push_sel <= '0;
            if (commit_fall) push_sel[commit_queue] <= 1'b1;
        end
    end

    // descriptor sampled together with the strobe
    always_ff @(posedge clk) begin
        if (commit_fall) push_desc <= desc_in;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int q = 0; q < NQ; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            for (int q = 0; q < NQ; q++) begin
                if (push_ok[q]) wr_ptr[q] <= wr_ptr[q] + 1'b1;
                if (pop_hit[q]) rd_ptr[q] <= rd_ptr[q] + 1'b1;
                // push and pop together leave the count alone
                count[q] <= count[q] + CNT_W'(push_ok[q]) - CNT_W'(pop_hit[q]);
            end
        end
    end

    // storage and registered head read
    always_ff @(posedge clk) begin
        for (int q = 0; q < NQ; q++) begin
            if (push_ok[q]) mem[q][wr_ptr[q]] <= push_desc;
        end
        if (pop) head_desc <= mem[pop_idx][rd_ptr[pop_idx]];
    end

    assign queue_count0 = count[0];
    assign queue_count1 = count[1];
    assign queue_count2 = count[2];
    assign queue_count3 = count[3];

endmodule

`default_nettype wire

//--- hdl/tx_arbiter.sv
// serves one packet at a time; a new grant waits for frame_done of the previous one
`default_nettype none

module tx_arbiter (
    input  wire                               clk,
    input  wire                               rstn,
    input  wire [tx_cfg_pkg::NUM_QUEUES-1:0]  queue_allowed,
    input  wire [tx_cfg_pkg::NUM_QUEUES-1:0]  queue_empty,
    input  wire                               bb_busy,
    input  wire [tx_cfg_pkg::DESC_W-1:0]      head_desc,
    input  wire                               frame_done,
    output logic                              pop,
    output logic [1:0]                        pop_idx,
    output logic                              desc_valid,
    output logic [tx_cfg_pkg::DESC_W-1:0]     desc,
    output logic [1:0]                        tx_queue_idx
);

    tx_cfg_pkg::arb_state_t state;
    logic       grant_any;
    logic [1:0] grant_idx;

    // lowest allowed non-empty queue wins
    // scan from the top so queue 0 is assigned last
    always_comb begin
        grant_any = 1'b0;
        grant_idx = '0;
        for (int q = tx_cfg_pkg::NUM_QUEUES - 1; q >= 0; q--) begin
            if (queue_allowed[q] && !queue_empty[q]) begin
                grant_any = 1'b1;
                grant_idx = 2'(q);
            end
        end
    end

    // pop in the grant cycle itself, head shows up during FETCH
    assign pop        = (state == tx_cfg_pkg::ARB_IDLE) && grant_any && !bb_busy;
    assign pop_idx    = grant_idx;
    assign desc_valid = (state == tx_cfg_pkg::ARB_HANDOFF);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= tx_cfg_pkg::ARB_IDLE;
            tx_queue_idx <= '0;
        end else begin
            case (state)
                tx_cfg_pkg::ARB_IDLE: begin
                    if (pop) begin
                        tx_queue_idx <= grant_idx;
                        state        <= tx_cfg_pkg::ARB_FETCH;
                    end
                end
                tx_cfg_pkg::ARB_FETCH:   state <= tx_cfg_pkg::ARB_HANDOFF;
                tx_cfg_pkg::ARB_HANDOFF: state <= tx_cfg_pkg::ARB_WAIT_DONE;
                // index held here for the whole packet
                tx_cfg_pkg::ARB_WAIT_DONE: begin
                    if (frame_done) state <= tx_cfg_pkg::ARB_IDLE;
                end
                default: state <= tx_cfg_pkg::ARB_IDLE;
            endcase
        end
    end

    // latch the popped head
    always_ff @(posedge clk) begin
        if (state == tx_cfg_pkg::ARB_FETCH) desc <= head_desc;
    end

endmodule

`default_nettype wire

//--- hdl/frame_writer.sv
// header layout assumes DATA_W of 64; desc_valid must only arrive while idle
`default_nettype none

module frame_writer #(
    parameter int DATA_W = 64,
    parameter int ADDR_W = 10
) (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           desc_valid,
    input  wire [tx_cfg_pkg::DESC_W-1:0]  desc,
    input  wire [47:0]                    mac_addr,
    input  wire [13:0]                    sifs_cycles,
    input  wire [DATA_W-1:0]              dma_data,
    input  wire                           dma_emptyn,
    input  wire                           tx_end,
    output logic                          dma_ask,
    output logic                          frame_done,
    output logic                          wr_en,
    output logic [ADDR_W-1:0]             wr_addr,
    output logic [DATA_W-1:0]             wr_data
);

    localparam int HDR_W = $clog2(wifi_frame_pkg::CTS_WORDS);
    localparam int LEN_W = tx_cfg_pkg::LEN_W;

    tx_cfg_pkg::wr_state_t state;
    logic [tx_cfg_pkg::DESC_W-1:0] cur_desc;
    logic [HDR_W-1:0]              hdr_cnt;
    logic [13:0]                   sifs_cnt;
    logic [LEN_W-1:0]              word_cnt;
    logic [LEN_W-1:0]              pkt_len;
    logic [ADDR_W-1:0]             wr_ptr;
    logic [tx_cfg_pkg::RATE_W-1:0] cts_rate;
    logic [DATA_W-1:0]             hdr_word;
    logic                          accept;

    assign pkt_len = cur_desc[LEN_W-1:0];
    // word taken when both sides agree
    assign accept  = dma_ask && dma_emptyn;
    assign frame_done = (state == tx_cfg_pkg::WR_PAYLOAD) && tx_end;

    // rate sel high picks the data rate
    assign cts_rate = cur_desc[tx_cfg_pkg::RATE_SEL_BIT]
                    ? cur_desc[tx_cfg_pkg::PKT_RATE_LSB +: tx_cfg_pkg::RATE_W]
                    : cur_desc[tx_cfg_pkg::CTS_RATE_LSB +: tx_cfg_pkg::RATE_W];

    always_comb begin
        case (hdr_cnt)
            // signal field: rate, reserved, length, parity
            2'd0: hdr_word = DATA_W'({wifi_frame_pkg::signal_parity(cts_rate),
                                      wifi_frame_pkg::SIGNAL_LEN, 1'b0, cts_rate});
            // frame control, duration, ra low
            2'd2: hdr_word = {mac_addr[31:0],
                              cur_desc[tx_cfg_pkg::DUR_LSB +: tx_cfg_pkg::DUR_W], 8'd0,
                              wifi_frame_pkg::FC_SUBTYPE_CTS, wifi_frame_pkg::FC_TYPE_CTRL,
                              2'b00};
            2'd3: hdr_word = DATA_W'(mac_addr[47:32]);
            default: hdr_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= tx_cfg_pkg::WR_IDLE;
            dma_ask  <= 1'b0;
            wr_en    <= 1'b0;
            hdr_cnt  <= '0;
            sifs_cnt <= '0;
            word_cnt <= '0;
            wr_ptr   <= '0;
        end else begin
            wr_en <= (state == tx_cfg_pkg::WR_CTS) || accept;
            case (state)
                tx_cfg_pkg::WR_IDLE: begin
                    if (desc_valid) state <= tx_cfg_pkg::WR_JUDGE;
                end
                tx_cfg_pkg::WR_JUDGE: begin
                    hdr_cnt  <= '0;
                    sifs_cnt <= '0;
                    word_cnt <= '0;
                    if (cur_desc[tx_cfg_pkg::CTS_EN_BIT]) begin
                        // payload goes behind the header
                        wr_ptr <= ADDR_W'(wifi_frame_pkg::CTS_WORDS);
                        state  <= tx_cfg_pkg::WR_CTS;
                    end else begin
                        wr_ptr  <= '0;
                        dma_ask <= (pkt_len != '0);
                        state   <= tx_cfg_pkg::WR_PAYLOAD;
                    end
                end
                tx_cfg_pkg::WR_CTS: begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (hdr_cnt == HDR_W'(wifi_frame_pkg::CTS_WORDS - 1)) begin
                        state <= tx_cfg_pkg::WR_SIFS;
                    end
                end
                // sifs_cycles + 1 clocks of gap
                tx_cfg_pkg::WR_SIFS: begin
                    sifs_cnt <= sifs_cnt + 1'b1;
                    if (sifs_cnt == sifs_cycles) begin
                        dma_ask <= (pkt_len != '0);
                        state   <= tx_cfg_pkg::WR_PAYLOAD;
                    end
                end
                tx_cfg_pkg::WR_PAYLOAD: begin
                    if (accept) begin
                        wr_ptr   <= wr_ptr + 1'b1;
                        word_cnt <= word_cnt + 1'b1;
                        // stop asking after the last word
                        if (word_cnt == pkt_len - 1'b1) dma_ask <= 1'b0;
                    end
                    if (tx_end) begin
                        dma_ask <= 1'b0;
                        state   <= tx_cfg_pkg::WR_IDLE;
                    end
                end
                default: state <= tx_cfg_pkg::WR_IDLE;
            endcase
        end
    end

    // write address and data, header or stream
    always_ff @(posedge clk) begin
        if (desc_valid) cur_desc <= desc;
        if (state == tx_cfg_pkg::WR_CTS) begin
            wr_addr <= ADDR_W'(hdr_cnt);
            wr_data <= hdr_word;
        end else begin
            wr_addr <= wr_ptr;
            wr_data <= dma_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pkt_buffer.sv
// start fires on a write to start_threshold; a threshold never written gives no pulse
`default_nettype none

module pkt_buffer #(
    parameter int DATA_W = 64,
    parameter int ADDR_W = 10
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               wr_en,
    input  wire [ADDR_W-1:0]  wr_addr,
    input  wire [DATA_W-1:0]  wr_data,
    input  wire [ADDR_W-1:0]  start_threshold,
    input  wire [ADDR_W-1:0]  phy_addr,
    output logic [DATA_W-1:0] phy_data,
    output logic              start
);

    localparam int PULSE_W = $clog2(tx_cfg_pkg::START_PULSE_CYCLES + 1);

    logic [DATA_W-1:0]  mem [2**ADDR_W];
    logic [PULSE_W-1:0] pulse_cnt;
    logic               hit;

    // writer side
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // phy side, one clock read latency
    always_ff @(posedge clk) begin
        phy_data <= mem[phy_addr];
    end

    // threshold write starts the phy
    assign hit = wr_en && (wr_addr == start_threshold);

    // stretch to START_PULSE_CYCLES
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pulse_cnt <= '0;
        end else if (hit) begin
            pulse_cnt <= PULSE_W'(tx_cfg_pkg::START_PULSE_CYCLES);
        end else if (pulse_cnt != '0) begin
            pulse_cnt <= pulse_cnt - 1'b1;
        end
    end

    assign start = (pulse_cnt != '0);

endmodule

`default_nettype wire

//--- hdl/tx_bit_intf.sv
// one packet in flight at a time; payload lands at 0, or behind a 4-word cts header
`default_nettype none

module tx_bit_intf #(
    parameter int DATA_W      = 64,
    parameter int ADDR_W      = 10,
    parameter int QUEUE_DEPTH = 64,
    localparam int CNT_W      = $clog2(QUEUE_DEPTH) + 1
) (
    input  wire                              clk,
    input  wire                              rstn,
    // host stream and descriptor commit
    input  wire [DATA_W-1:0]                 dma_data,
    input  wire                              dma_emptyn,
    output logic                             dma_ask,
    input  wire [31:0]                       desc_word,
    input  wire [31:0]                       cts_config,
    input  wire                              commit,
    input  wire [1:0]                        commit_queue,
    // mac side control
    input  wire [tx_cfg_pkg::NUM_QUEUES-1:0] queue_allowed,
    input  wire                              bb_busy,
    input  wire [ADDR_W-1:0]                 start_threshold,
    input  wire [13:0]                       sifs_cycles,
    input  wire [47:0]                       mac_addr,
    output logic [1:0]                       tx_queue_idx,
    output logic [CNT_W-1:0]                 queue_count0,
    output logic [CNT_W-1:0]                 queue_count1,
    output logic [CNT_W-1:0]                 queue_count2,
    output logic [CNT_W-1:0]                 queue_count3,
    // phy
    input  wire                              tx_end,
    input  wire [ADDR_W-1:0]                 phy_addr,
    output logic [DATA_W-1:0]                phy_data,
    output logic                             start
);

    logic [tx_cfg_pkg::NUM_QUEUES-1:0] queue_empty;
    logic [tx_cfg_pkg::DESC_W-1:0]     head_desc;
    logic [tx_cfg_pkg::DESC_W-1:0]     desc;
    logic                              pop;
    logic [1:0]                        pop_idx;
    logic                              desc_valid;
    logic                              frame_done;
    logic                              wr_en;
    logic [ADDR_W-1:0]                 wr_addr;
    logic [DATA_W-1:0]                 wr_data;

    // cts_config rides in the upper half
    desc_queues #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_desc_queues (
        .clk(clk), .rstn(rstn), .commit(commit), .commit_queue(commit_queue),
        .desc_in({cts_config, desc_word}), .pop(pop), .pop_idx(pop_idx),
        .queue_empty(queue_empty), .head_desc(head_desc),
        .queue_count0(queue_count0), .queue_count1(queue_count1),
        .queue_count2(queue_count2), .queue_count3(queue_count3)
    );

    tx_arbiter i_tx_arbiter (
        .clk(clk), .rstn(rstn), .queue_allowed(queue_allowed), .queue_empty(queue_empty),
        .bb_busy(bb_busy), .head_desc(head_desc), .frame_done(frame_done), .pop(pop),
        .pop_idx(pop_idx), .desc_valid(desc_valid), .desc(desc), .tx_queue_idx(tx_queue_idx)
    );

    frame_writer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_frame_writer (
        .clk(clk), .rstn(rstn), .desc_valid(desc_valid), .desc(desc), .mac_addr(mac_addr),
        .sifs_cycles(sifs_cycles), .dma_data(dma_data), .dma_emptyn(dma_emptyn),
        .tx_end(tx_end), .dma_ask(dma_ask), .frame_done(frame_done), .wr_en(wr_en),
        .wr_addr(wr_addr), .wr_data(wr_data)
    );

    pkt_buffer #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_pkt_buffer (
        .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .start_threshold(start_threshold), .phy_addr(phy_addr), .phy_data(phy_data),
        .start(start)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// free-running clock from time 0; rstn is released on a rising edge after RESET_CYCLES clocks
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    // even duty cycle
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low for the first clocks
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tx_bit_intf_checker.sv
// samples on the rising edge; all but the reset property are held off while rstn is low
`default_nettype none

module tx_bit_intf_checker (
    input wire       clk,
    input wire       rstn,
    input wire       dma_ask,
    input wire       start,
    input wire [1:0] tx_queue_idx
);

    localparam int PULSE = tx_cfg_pkg::START_PULSE_CYCLES;

    // number of assertion failures so far
    int fail_count = 0;

    // sync reset clears the ask one clock later
    ask_low_after_reset: assert property (@(posedge clk) !rstn |=> !dma_ask)
        else begin
            $error("dma_ask still high one cycle after reset");
            fail_count = fail_count + 1;
        end

    // stretched strobe of exactly PULSE clocks
    start_width: assert property (@(posedge clk) disable iff (!rstn)
        $rose(start) |-> start [*PULSE] ##1 !start)
        else begin
            $error("start pulse width differs from %0d cycles", PULSE);
            fail_count = fail_count + 1;
        end

    // served queue fixed for the whole transfer
    qidx_stable: assert property (@(posedge clk) disable iff (!rstn)
        dma_ask && $past(dma_ask) |-> $stable(tx_queue_idx))
        else begin
            $error("tx_queue_idx changed while dma_ask was high");
            fail_count = fail_count + 1;
        end

endmodule

bind tx_bit_intf tx_bit_intf_checker i_tx_bit_intf_checker (
    .clk(clk),
    .rstn(rstn),
    .dma_ask(dma_ask),
    .start(start),
    .tx_queue_idx(tx_queue_idx)
);

`default_nettype wire

//--- verification/tb_tx_bit_intf.sv
// one packet in flight; each buffer image is read back through the phy port before tx_end
`default_nettype none

module tb_tx_bit_intf;

    localparam int DATA_W      = 64;
    localparam int ADDR_W      = 10;
    localparam int QUEUE_DEPTH = 64;
    localparam int CNT_W       = $clog2(QUEUE_DEPTH) + 1;
    localparam int NUM_PKTS    = 12;
    localparam int SIFS        = 10;
    localparam int PERIOD      = 4;
    localparam int CTS_WORDS   = wifi_frame_pkg::CTS_WORDS;
    // per packet budget with 2x margin, plus reset, commit and busy phases
    localparam int WATCHDOG_T  = NUM_PKTS * (48 + SIFS + 16) * 2 * PERIOD
                               + (NUM_PKTS * 8 + 64) * PERIOD;

    wire               clk;
    wire               rstn;
    logic [DATA_W-1:0] dma_data;
    logic              dma_emptyn;
    logic [31:0]       desc_word;
    logic [31:0]       cts_config;
    logic              commit;
    logic [1:0]        commit_queue;
    logic [3:0]        queue_allowed;
    logic              bb_busy;
    logic [ADDR_W-1:0] start_threshold;
    logic [13:0]       sifs_cycles;
    logic [47:0]       mac_addr;
    logic              tx_end;
    logic [ADDR_W-1:0] phy_addr;
    wire               dma_ask;
    wire               start;
    wire [1:0]         tx_queue_idx;
    wire [CNT_W-1:0]   queue_count0;
    wire [CNT_W-1:0]   queue_count1;
    wire [CNT_W-1:0]   queue_count2;
    wire [CNT_W-1:0]   queue_count3;
    wire [DATA_W-1:0]  phy_data;

    int errors      = 0;
    int checks      = 0;
    int tests       = 0;
    int pulse_run   = 0;
    int pulse_seen  = 0;
    int pulse_width = 0;
    int thr         = 0;
    logic [3:0] cur_mask;
    // model of the per-queue descriptor lists and the expected buffer image
    logic [63:0]       model_desc [4][NUM_PKTS];
    int                model_head [4];
    int                model_tail [4];
    logic [DATA_W-1:0] exp_img [CTS_WORDS + 64];

    tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(3)) i_tb_clock (.clk(clk), .rstn(rstn));

    tx_bit_intf #(.DATA_W(DATA_W), .ADDR_W(ADDR_W), .QUEUE_DEPTH(QUEUE_DEPTH)) i_tx_bit_intf (
        .clk(clk), .rstn(rstn), .dma_data(dma_data), .dma_emptyn(dma_emptyn),
        .dma_ask(dma_ask), .desc_word(desc_word), .cts_config(cts_config),
        .commit(commit), .commit_queue(commit_queue), .queue_allowed(queue_allowed),
        .bb_busy(bb_busy), .start_threshold(start_threshold), .sifs_cycles(sifs_cycles),
        .mac_addr(mac_addr), .tx_queue_idx(tx_queue_idx), .queue_count0(queue_count0),
        .queue_count1(queue_count1), .queue_count2(queue_count2),
        .queue_count3(queue_count3), .tx_end(tx_end), .phy_addr(phy_addr),
        .phy_data(phy_data), .start(start)
    );

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
                               input logic [CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_qidx(input string name, input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic check_pulse(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) $display("test %s ok", name);
        else $display("test %s has %0d errors", name, errors - err0);
    endtask

    task automatic check_all_counts();
        check_count("queue_count0", queue_count0, CNT_W'(model_tail[0] - model_head[0]));
        check_count("queue_count1", queue_count1, CNT_W'(model_tail[1] - model_head[1]));
        check_count("queue_count2", queue_count2, CNT_W'(model_tail[2] - model_head[2]));
        check_count("queue_count3", queue_count3, CNT_W'(model_tail[3] - model_head[3]));
    endtask

    // lowest allowed queue that still holds a descriptor
    function automatic int pick_queue(input logic [3:0] mask);
        for (int q = 0; q < 4; q++) begin
            if (mask[q] && (model_tail[q] > model_head[q])) return q;
        end
        return -1;
    endfunction

    // cts-to-self header built from the descriptor and the station address
    function automatic logic [DATA_W-1:0] cts_header_word(input logic [63:0] d, input int idx);
        logic [3:0]        rate;
        logic [DATA_W-1:0] w;
        rate = d[tx_cfg_pkg::RATE_SEL_BIT] ? d[tx_cfg_pkg::PKT_RATE_LSB +: 4]
                                           : d[tx_cfg_pkg::CTS_RATE_LSB +: 4];
        case (idx)
            // bit 17 makes the ones over rate, length and parity even
            0: w = {46'd0, ^{rate, wifi_frame_pkg::SIGNAL_LEN}, wifi_frame_pkg::SIGNAL_LEN,
                    1'b0, rate};
            2: w = {mac_addr[31:0], d[tx_cfg_pkg::DUR_LSB +: 16], 8'd0,
                    wifi_frame_pkg::FC_SUBTYPE_CTS, wifi_frame_pkg::FC_TYPE_CTRL, 2'b00};
            3: w = {48'd0, mac_addr[47:32]};
            default: w = '0;
        endcase
        return w;
    endfunction

    // raise and drop commit, then wait for the count to move
    task automatic commit_desc(input int q, input logic [31:0] dw, input logic [31:0] cfg);
        @(posedge clk);
        commit       <= 1'b1;
        commit_queue <= 2'(q);
        desc_word    <= dw;
        cts_config   <= cfg;
        @(posedge clk);
        commit <= 1'b0;
        // fall seen, write strobe, count update
        repeat (2) @(posedge clk);
        @(negedge clk);
        model_desc[q][model_tail[q]] = {cfg, dw};
        model_tail[q]++;
        check_all_counts();
    endtask

    // new mask and threshold for the next grant
    task automatic choose_next();
        cur_mask = 4'($urandom);
        if (pick_queue(cur_mask) < 0) cur_mask = 4'hf;
        thr = $urandom_range(47, 0);
        queue_allowed   <= cur_mask;
        start_threshold <= ADDR_W'(thr);
    endtask

    task automatic serve_packet(input int n);
        int          q;
        int          len;
        int          base;
        int          got;
        int          nw;
        int          pulses0;
        int          exp_pulses;
        int          err0;
        logic [63:0] d;
        err0 = errors;
        q = pick_queue(cur_mask);
        if (q < 0) begin
            errors++;
            $display("packet %0d has no queue left to serve", n);
            return;
        end
        d = model_desc[q][model_head[q]];
        model_head[q]++;
        len     = int'(d[tx_cfg_pkg::LEN_W-1:0]);
        base    = d[tx_cfg_pkg::CTS_EN_BIT] ? CTS_WORDS : 0;
        nw      = base + len;
        pulses0 = pulse_seen;
        exp_pulses = (thr < nw) ? 1 : 0;
        for (int i = 0; i < base; i++) exp_img[i] = cts_header_word(d, i);
        // writer asks once header and sifs are done
        @(negedge clk);
        while (dma_ask !== 1'b1) @(negedge clk);
        check_qidx("tx_queue_idx", tx_queue_idx, 2'(q));
        check_all_counts();
        got = 0;
        while (got < len) begin
            @(posedge clk);
            // pre-edge values as the DUT sampled them
            if (dma_ask && dma_emptyn) begin
                exp_img[base + got] = dma_data;
                got++;
            end
            if (got < len) begin
                dma_data   <= {$urandom, $urandom};
                dma_emptyn <= ($urandom_range(3, 0) != 0);
            end else begin
                dma_emptyn <= 1'b0;
            end
        end
        @(negedge clk);
        check_pulse("dma_ask", int'(dma_ask), 0);
        // last write lands and start runs out
        repeat (tx_cfg_pkg::START_PULSE_CYCLES + 4) @(posedge clk);
        // pipelined readback with word a-1 showing at the negedge of step a
        for (int a = 0; a <= nw; a++) begin
            @(posedge clk);
            if (a < nw) phy_addr <= ADDR_W'(a);
            @(negedge clk);
            if (a > 0) check_word($sformatf("phy_data[%0d]", a - 1), phy_data, exp_img[a - 1]);
        end
        check_pulse("start pulses", pulse_seen - pulses0, exp_pulses);
        if (pulse_seen - pulses0 == 1) begin
            check_pulse("start width", pulse_width, tx_cfg_pkg::START_PULSE_CYCLES);
        end
        @(posedge clk);
        tx_end <= 1'b1;
        choose_next();
        @(posedge clk);
        tx_end <= 1'b0;
        report_test($sformatf("packet %0d q%0d len %0d cts %0d", n, q, len, base != 0), err0);
    endtask

    // start high-time counter
    always @(negedge clk) begin
        if (start === 1'b1) begin
            pulse_run = pulse_run + 1;
        end else if (pulse_run != 0) begin
            pulse_seen  = pulse_seen + 1;
            pulse_width = pulse_run;
            pulse_run   = 0;
        end
    end

    initial begin
        #(WATCHDOG_T);
        $display("timeout at %0t, the DUT stopped making progress", $time);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int          err0;
        int          q;
        logic [31:0] dw;
        void'($urandom(32'h25aa6cae));
        dma_data        = '0;
        dma_emptyn      = 1'b0;
        desc_word       = '0;
        cts_config      = '0;
        commit          = 1'b0;
        commit_queue    = '0;
        queue_allowed   = 4'h0;
        bb_busy         = 1'b1;
        start_threshold = '0;
        sifs_cycles     = 14'(SIFS);
        mac_addr        = 48'({$urandom, $urandom});
        tx_end          = 1'b0;
        phy_addr        = '0;
        cur_mask        = 4'h0;
        for (int i = 0; i < 4; i++) begin
            model_head[i] = 0;
            model_tail[i] = 0;
        end
        wait (rstn === 1'b1);
        @(negedge clk);
        err0 = errors;
        check_pulse("dma_ask", int'(dma_ask), 0);
        check_pulse("start", int'(start), 0);
        check_all_counts();
        report_test("reset", err0);
        // fill the queues with nothing allowed
        err0 = errors;
        for (int n = 0; n < NUM_PKTS; n++) begin
            q  = $urandom_range(3, 0);
            dw = $urandom;
            dw[12:0] = 13'($urandom_range(40, 4));
            commit_desc(q, dw, $urandom);
        end
        report_test("commit", err0);
        // all queues allowed but baseband busy
        err0 = errors;
        @(posedge clk);
        queue_allowed <= 4'hf;
        repeat (20) begin
            @(negedge clk);
            check_pulse("dma_ask", int'(dma_ask), 0);
        end
        report_test("busy", err0);
        @(posedge clk);
        choose_next();
        bb_busy <= 1'b0;
        for (int n = 0; n < NUM_PKTS; n++) serve_packet(n);
        // bound assertions count toward the verdict
        if (i_tx_bit_intf.i_tx_bit_intf_checker.fail_count != 0) begin
            errors += i_tx_bit_intf.i_tx_bit_intf_checker.fail_count;
            $display("checker assertions failed %0d times",
                     i_tx_bit_intf.i_tx_bit_intf_checker.fail_count);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/tx_cfg_pkg.sv
hdl/wifi_frame_pkg.sv
hdl/desc_queues.sv
hdl/tx_arbiter.sv
hdl/frame_writer.sv
hdl/pkt_buffer.sv
hdl/tx_bit_intf.sv
verification/tb_clock.sv
verification/tx_bit_intf_checker.sv
verification/tb_tx_bit_intf.sv
